//--- aes_defs.svh
`ifndef AES_DEFS_SVH
`define AES_DEFS_SVH

////////////////////////////////////////////////////////////
// AXI-Lite control port
////////////////////////////////////////////////////////////

// Data width of the register port
`define AES_AXIL_DATA_BITS 64
// Byte address, 8 registers of 8 bytes at most
`define AES_AXIL_ADDR_BITS 6
// Key lo/hi, IV lo/hi, destination
`define AES_N_REGS 5

////////////////////////////////////////////////////////////
// Streams and cipher
////////////////////////////////////////////////////////////

// Destination tag on each beat
`define AES_DEST_BITS 6
// Slots per stream FIFO, also the credits a sender starts with
`define AES_FIFO_DEPTH 4
// AES-128 round count
`define AES_ROUNDS 10

`endif

//--- axil_pkg.sv
`include "aes_defs.svh"

package axil_pkg;

  // Response code, the only one the slave returns
  localparam logic [1:0] RESP_OKAY = 2'b00;

  // Master to slave, all five channels in one bundle
  typedef struct packed {
    logic [`AES_AXIL_ADDR_BITS-1:0]   awaddr;
    logic                             awvalid;
    logic [`AES_AXIL_DATA_BITS-1:0]   wdata;
    logic [`AES_AXIL_DATA_BITS/8-1:0] wstrb;
    logic                             wvalid;
    logic                             bready;
    logic [`AES_AXIL_ADDR_BITS-1:0]   araddr;
    logic                             arvalid;
    logic                             rready;
  } axil_req_t;

  // Slave to master
  typedef struct packed {
    logic                           awready;
    logic                           wready;
    logic [1:0]                     bresp;
    logic                           bvalid;
    logic                           arready;
    logic [`AES_AXIL_DATA_BITS-1:0] rdata;
    logic [1:0]                     rresp;
    logic                           rvalid;
  } axil_rsp_t;

endpackage

//--- aes_pkg.sv
`include "aes_defs.svh"

package aes_pkg;

  // One AES state, byte 0 in bits 127:120
  typedef logic [127:0] aes_block_t;

  // Input stream beat
  typedef struct packed {
    aes_block_t                data;
    logic [`AES_DEST_BITS-1:0] dest;
  } aes_beat_t;

  // Output stream beat
  typedef struct packed {
    aes_block_t                data;
    logic [`AES_DEST_BITS-1:0] dest;
    // High when data went through the cipher
    logic                      enc;
  } aes_out_beat_t;

  // Programmed configuration, parser to engine
  typedef struct packed {
    aes_block_t                key;
    aes_block_t                iv;
    logic [`AES_DEST_BITS-1:0] dest;
  } aes_cfg_t;

  ////////////////////////////////////////////////////////////
  // Register map, index times 8 gives the byte address
  ////////////////////////////////////////////////////////////

  localparam int KEY_LO_REG = 0;
  localparam int KEY_HI_REG = 1;
  localparam int IV_LO_REG  = 2;
  localparam int IV_HI_REG  = 3;
  // Write-only, reads back as zero
  localparam int DEST_REG   = 4;

endpackage

//--- aes_sbox.sv
`timescale 1ns/10ps

module aes_sbox (
  input  logic [7:0] in_byte,
  output logic [7:0] out_byte
);

  // Running power x^(2^k) and the inverse accumulator
  logic [7:0] pw;
  logic [7:0] inv;

  // GF(2^8) product modulo x^8 + x^4 + x^3 + x + 1
  function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
    logic [7:0] p;
    logic [7:0] t;
    p = 8'h00;
    t = a;
    for (int i = 0; i < 8; i++) begin
      if (b[i]) begin
        p = p ^ t;
      end
      t = {t[6:0], 1'b0} ^ (t[7] ? 8'h1b : 8'h00);
    end
    return p;
  endfunction

  // Inverse as x^254 = x^2 * x^4 * ... * x^128
  // Zero stays zero, so 0x00 comes out as 0x63
  always_comb begin
    pw  = in_byte;
    inv = 8'h01;
    for (int k = 1; k < 8; k++) begin
      pw  = gf_mul(pw, pw);
      inv = gf_mul(inv, pw);
    end
  end

  // Affine map, xor of four left rotations plus 0x63
  assign out_byte = inv ^
                    {inv[6:0], inv[7]} ^
                    {inv[5:0], inv[7:6]} ^
                    {inv[4:0], inv[7:5]} ^
                    {inv[3:0], inv[7:4]} ^
                    8'h63;

endmodule

//--- aes_stream_fifo.sv
`timescale 1ns/10ps

module aes_stream_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 4
) (
  input  logic     aclk,
  input  logic     aresetn,
  input  logic     wr_valid,
  input  payload_t wr_data,
  input  logic     rd_pop,
  output logic     rd_avail,
  output payload_t rd_data,
  output logic     credit
);

  localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_BITS = $clog2(DEPTH + 1);

  payload_t            mem [DEPTH];
  logic [PTR_BITS-1:0] wr_ptr;
  logic [PTR_BITS-1:0] rd_ptr;
  logic [CNT_BITS-1:0] count;
  logic                do_pop;

  // Wrap at DEPTH, so any depth works
  function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] p);
    return (p == PTR_BITS'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign rd_avail = (count != '0);
  assign rd_data  = mem[rd_ptr];
  assign do_pop   = rd_pop && rd_avail;

  // Sender is credit-limited, no full check
  always_ff @(posedge aclk) begin
    if (wr_valid) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      credit <= 1'b0;
    end else begin
      if (wr_valid) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({wr_valid, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;
      endcase
      // One credit back per freed slot
      credit <= do_pop;
    end
  end

endmodule

//--- aes_ctrl_parser.sv
`timescale 1ns/10ps
`include "aes_defs.svh"

module aes_ctrl_parser (
  input  logic                aclk,
  input  logic                aresetn,
  input  axil_pkg::axil_req_t axil_req,
  output axil_pkg::axil_rsp_t axil_rsp,
  output aes_pkg::aes_cfg_t   cfg,
  output logic                key_valid,
  output logic                iv_valid
);

  localparam int STRB_BITS = `AES_AXIL_DATA_BITS / 8;
  localparam int IDX_LSB   = $clog2(STRB_BITS);
  localparam int IDX_BITS  = `AES_AXIL_ADDR_BITS - IDX_LSB;

  // Register file
  logic [`AES_N_REGS-1:0][`AES_AXIL_DATA_BITS-1:0] regs;

  // Latched register indices of the accepted requests
  logic [IDX_BITS-1:0] aw_idx;
  logic [IDX_BITS-1:0] ar_idx;

  // Handshake state
  logic aw_en;
  logic wr_ready;
  logic bvalid;
  logic arready;
  logic rvalid;
  logic [`AES_AXIL_DATA_BITS-1:0] rdata;
  logic wr_en;
  logic rd_en;

  ////////////////////////////////////////////////////////////
  // Write channel
  ////////////////////////////////////////////////////////////

  // Address and data accepted together in one beat
  assign wr_en = wr_ready && axil_req.awvalid && axil_req.wvalid;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_ready <= 1'b0;
      aw_en    <= 1'b1;
      aw_idx   <= '0;
      bvalid   <= 1'b0;
    end else begin
      wr_ready <= 1'b0;
      // One write outstanding, aw_en reopens on the B handshake
      if (!wr_ready && axil_req.awvalid && axil_req.wvalid && aw_en) begin
        wr_ready <= 1'b1;
        aw_en    <= 1'b0;
        aw_idx   <= axil_req.awaddr[IDX_LSB +: IDX_BITS];
      end else if (bvalid && axil_req.bready) begin
        aw_en <= 1'b1;
      end
      // Response the cycle after the data beat
      if (wr_en) begin
        bvalid <= 1'b1;
      end else if (bvalid && axil_req.bready) begin
        bvalid <= 1'b0;
      end
    end
  end

  // Byte-strobed register update and config pulses
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      regs      <= '0;
      key_valid <= 1'b0;
      iv_valid  <= 1'b0;
    end else begin
      // Key complete once its upper half lands
      key_valid <= wr_en && (aw_idx == IDX_BITS'(aes_pkg::KEY_HI_REG)) &&
                   (|axil_req.wstrb);
      // Destination write arms the IV and restarts the counter
      iv_valid  <= wr_en && (aw_idx == IDX_BITS'(aes_pkg::DEST_REG)) &&
                   (|axil_req.wstrb);
      if (wr_en && (aw_idx < IDX_BITS'(`AES_N_REGS))) begin
        for (int b = 0; b < STRB_BITS; b++) begin
          // Unstrobed bytes keep old value
          if (axil_req.wstrb[b]) begin
            regs[aw_idx][8*b +: 8] <= axil_req.wdata[8*b +: 8];
          end
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Read channel
  ////////////////////////////////////////////////////////////

  assign rd_en = arready && axil_req.arvalid && !rvalid;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      arready <= 1'b0;
      ar_idx  <= '0;
      rvalid  <= 1'b0;
    end else begin
      arready <= 1'b0;
      if (!arready && axil_req.arvalid && !rvalid) begin
        arready <= 1'b1;
        ar_idx  <= axil_req.araddr[IDX_LSB +: IDX_BITS];
      end
      if (rd_en) begin
        rvalid <= 1'b1;
      end else if (rvalid && axil_req.rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  // Readback mux, key and IV halves only
  always_ff @(posedge aclk) begin
    if (rd_en) begin
      case (ar_idx)
        IDX_BITS'(aes_pkg::KEY_LO_REG): rdata <= regs[aes_pkg::KEY_LO_REG];
        IDX_BITS'(aes_pkg::KEY_HI_REG): rdata <= regs[aes_pkg::KEY_HI_REG];
        IDX_BITS'(aes_pkg::IV_LO_REG):  rdata <= regs[aes_pkg::IV_LO_REG];
        IDX_BITS'(aes_pkg::IV_HI_REG):  rdata <= regs[aes_pkg::IV_HI_REG];
        default:                        rdata <= '0;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////

  always_comb begin
    axil_rsp         = '0;
    axil_rsp.awready = wr_ready;
    axil_rsp.wready  = wr_ready;
    axil_rsp.bresp   = axil_pkg::RESP_OKAY;
    axil_rsp.bvalid  = bvalid;
    axil_rsp.arready = arready;
    axil_rsp.rdata   = rdata;
    axil_rsp.rresp   = axil_pkg::RESP_OKAY;
    axil_rsp.rvalid  = rvalid;
  end

  // Hi register holds the upper 64 bits
  always_comb begin
    cfg.key  = {regs[aes_pkg::KEY_HI_REG], regs[aes_pkg::KEY_LO_REG]};
    cfg.iv   = {regs[aes_pkg::IV_HI_REG], regs[aes_pkg::IV_LO_REG]};
    cfg.dest = regs[aes_pkg::DEST_REG][`AES_DEST_BITS-1:0];
  end

endmodule

//--- aes_ctr_engine.sv
`timescale 1ns/10ps
`include "aes_defs.svh"

module aes_ctr_engine (
  input  logic                   aclk,
  input  logic                   aresetn,
  input  aes_pkg::aes_cfg_t      cfg,
  input  logic                   key_valid,
  input  logic                   iv_valid,
  input  logic                   in_avail,
  input  aes_pkg::aes_beat_t     in_beat,
  output logic                   in_pop,
  output logic                   out_push,
  output aes_pkg::aes_out_beat_t out_beat,
  input  logic                   out_credit
);

  localparam int CRED_BITS = $clog2(`AES_FIFO_DEPTH + 1);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_RUN,
    ST_SEND
  } state_t;

  state_t               state;
  logic [CRED_BITS-1:0] credits;
  logic                 key_loaded;
  // IV + n, the next counter block to cipher
  aes_pkg::aes_block_t  ctr;
  // Popped beat, held until sent
  aes_pkg::aes_beat_t   hold;
  logic                 hold_enc;
  // Round state and current round key
  aes_pkg::aes_block_t  st;
  aes_pkg::aes_block_t  rk;
  aes_pkg::aes_block_t  rk_next;
  aes_pkg::aes_block_t  mixed;
  logic [3:0]           rnd;
  logic [7:0]           rcon;
  logic [7:0]           sb [16];
  logic [7:0]           col [4];
  logic [31:0]          rot_w;
  logic [31:0]          sub_w;
  logic [31:0]          temp_w;
  logic                 match;

  function automatic logic [7:0] xtime(input logic [7:0] b);
    return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
  endfunction

  ////////////////////////////////////////////////////////////
  // Pop decision
  ////////////////////////////////////////////////////////////

  assign match = (in_beat.dest == cfg.dest);

  // Needs an output credit; matching beats also wait for a key
  assign in_pop = (state == ST_IDLE) && in_avail && (credits != '0) &&
                  (!match || key_loaded);

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state      <= ST_IDLE;
      credits    <= CRED_BITS'(`AES_FIFO_DEPTH);
      key_loaded <= 1'b0;
      ctr        <= '0;
    end else begin
      if (key_valid) begin
        key_loaded <= 1'b1;
      end
      // Credit taken at pop, returned by the sink
      case ({in_pop, out_credit})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: ;
      endcase
      // New IV restarts n at zero
      if (iv_valid) begin
        ctr <= cfg.iv;
      end else if ((state == ST_SEND) && hold_enc) begin
        ctr <= ctr + 128'd1;
      end
      case (state)
        ST_IDLE: if (in_pop) state <= match ? ST_RUN : ST_SEND;
        ST_RUN:  if (rnd == 4'(`AES_ROUNDS)) state <= ST_SEND;
        ST_SEND: state <= ST_IDLE;
        default: state <= ST_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Iterative round, one per cycle
  ////////////////////////////////////////////////////////////

  always_ff @(posedge aclk) begin
    if (in_pop) begin
      hold     <= in_beat;
      hold_enc <= match;
      // Initial AddRoundKey on the counter block
      st       <= ctr ^ cfg.key;
      rk       <= cfg.key;
      rcon     <= 8'h01;
      rnd      <= 4'd1;
    end else if (state == ST_RUN) begin
      st   <= mixed ^ rk_next;
      rk   <= rk_next;
      rcon <= xtime(rcon);
      rnd  <= rnd + 4'd1;
    end
  end

  // SubBytes on all 16 state bytes
  for (genvar i = 0; i < 16; i++) begin : g_sbox
    aes_sbox i_sbox (
      .in_byte  (st[127-8*i -: 8]),
      .out_byte (sb[i])
    );
  end

  // ShiftRows then MixColumns, last round skips the mix
  always_comb begin
    mixed = '0;
    for (int c = 0; c < 4; c++) begin
      for (int r = 0; r < 4; r++) begin
        col[r] = sb[4*((c + r) % 4) + r];
      end
      if (rnd == 4'(`AES_ROUNDS)) begin
        mixed[127-32*c -: 32] = {col[0], col[1], col[2], col[3]};
      end else begin
        mixed[127-32*c -: 32] = {
          xtime(col[0]) ^ xtime(col[1]) ^ col[1] ^ col[2] ^ col[3],
          col[0] ^ xtime(col[1]) ^ xtime(col[2]) ^ col[2] ^ col[3],
          col[0] ^ col[1] ^ xtime(col[2]) ^ xtime(col[3]) ^ col[3],
          xtime(col[0]) ^ col[0] ^ col[1] ^ col[2] ^ xtime(col[3])
        };
      end
    end
  end

  // Key schedule, RotWord then SubWord on the last word
  assign rot_w = {rk[23:0], rk[31:24]};

  for (genvar j = 0; j < 4; j++) begin : g_ksbox
    aes_sbox i_ksbox (
      .in_byte  (rot_w[31-8*j -: 8]),
      .out_byte (sub_w[31-8*j -: 8])
    );
  end

  assign temp_w          = sub_w ^ {rcon, 24'h000000};
  assign rk_next[127:96] = rk[127:96] ^ temp_w;
  assign rk_next[95:64]  = rk[95:64] ^ rk_next[127:96];
  assign rk_next[63:32]  = rk[63:32] ^ rk_next[95:64];
  assign rk_next[31:0]   = rk[31:0] ^ rk_next[63:32];

  ////////////////////////////////////////////////////////////
  // Output beat
  ////////////////////////////////////////////////////////////

  assign out_push = (state == ST_SEND);

  // Keystream xor only for ciphered beats
  always_comb begin
    out_beat.data = hold_enc ? (hold.data ^ st) : hold.data;
    out_beat.dest = hold.dest;
    out_beat.enc  = hold_enc;
  end

endmodule

//--- aes_top.sv
`timescale 1ns/10ps
`include "aes_defs.svh"

module aes_top (
  input  logic                   aclk,
  input  logic                   aresetn,
  input  axil_pkg::axil_req_t    axil_req,
  output axil_pkg::axil_rsp_t    axil_rsp,
  input  logic                   in_valid,
  input  aes_pkg::aes_beat_t     in_beat,
  output logic                   in_credit,
  output logic                   out_valid,
  output aes_pkg::aes_out_beat_t out_beat,
  input  logic                   out_credit
);

  // Parser to engine
  aes_pkg::aes_cfg_t      cfg;
  logic                   key_valid;
  logic                   iv_valid;
  // Input FIFO to engine
  logic                   eng_avail;
  aes_pkg::aes_beat_t     eng_beat;
  logic                   eng_pop;
  // Engine to output FIFO
  logic                   eng_push;
  aes_pkg::aes_out_beat_t eng_out;

  aes_ctrl_parser i_ctrl_parser (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .axil_req  (axil_req),
    .axil_rsp  (axil_rsp),
    .cfg       (cfg),
    .key_valid (key_valid),
    .iv_valid  (iv_valid)
  );

  aes_stream_fifo #(
    .payload_t (aes_pkg::aes_beat_t),
    .DEPTH     (`AES_FIFO_DEPTH)
  ) i_in_fifo (
    .aclk     (aclk),
    .aresetn  (aresetn),
    .wr_valid (in_valid),
    .wr_data  (in_beat),
    .rd_pop   (eng_pop),
    .rd_avail (eng_avail),
    .rd_data  (eng_beat),
    .credit   (in_credit)
  );

  aes_ctr_engine i_ctr_engine (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .cfg        (cfg),
    .key_valid  (key_valid),
    .iv_valid   (iv_valid),
    .in_avail   (eng_avail),
    .in_beat    (eng_beat),
    .in_pop     (eng_pop),
    .out_push   (eng_push),
    .out_beat   (eng_out),
    .out_credit (out_credit)
  );

  // Sink takes every presented beat, so head pops as it shows
  // Engine counts the sink's credits, this FIFO's credit stays open
  aes_stream_fifo #(
    .payload_t (aes_pkg::aes_out_beat_t),
    .DEPTH     (`AES_FIFO_DEPTH)
  ) i_out_fifo (
    .aclk     (aclk),
    .aresetn  (aresetn),
    .wr_valid (eng_push),
    .wr_data  (eng_out),
    .rd_pop   (out_valid),
    .rd_avail (out_valid),
    .rd_data  (out_beat),
    .credit   ()
  );

endmodule

//--- aes_asserts.sv
`timescale 1ns/10ps
`include "aes_defs.svh"

module aes_asserts (
  input logic                   aclk,
  input logic                   aresetn,
  input axil_pkg::axil_req_t    axil_req,
  input axil_pkg::axil_rsp_t    axil_rsp,
  input logic                   in_valid,
  input aes_pkg::aes_beat_t     in_beat,
  input logic                   in_credit,
  input logic                   out_valid,
  input aes_pkg::aes_out_beat_t out_beat,
  input logic                   out_credit
);

  // FIPS-197 appendix C.1 vector
  localparam aes_pkg::aes_block_t FIPS_KEY = 128'h000102030405060708090a0b0c0d0e0f;
  localparam aes_pkg::aes_block_t FIPS_PT  = 128'h00112233445566778899aabbccddeeff;
  localparam aes_pkg::aes_block_t FIPS_CT  = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
  // 8-byte registers, index above bit 3
  localparam int IDX_HI = `AES_AXIL_ADDR_BITS - 1;
  localparam int IDX_LO = 3;

  int fail_cnt = 0;

  // Shadow copy of the register file, built from bus writes
  logic [`AES_AXIL_DATA_BITS-1:0] shadow [`AES_N_REGS];
  logic [`AES_AXIL_DATA_BITS-1:0] rd_exp;
  logic [IDX_HI-IDX_LO:0]         aw_idx;
  logic [IDX_HI-IDX_LO:0]         ar_idx;
  logic                           wr_hs;
  logic                           ar_hs;
  logic                           fips_cfg;
  logic [`AES_DEST_BITS-1:0]      cur_dest;

  // Scoreboard of sent beats, indexed by beat number
  aes_pkg::aes_beat_t  sent [256];
  aes_pkg::aes_beat_t  exp_beat;
  aes_pkg::aes_block_t keystream;
  int                  in_cnt;
  int                  out_cnt;
  int                  cred_cnt;
  int                  sink_cred;
  // Ciphered beats since the last DEST_REG write
  int                  n_enc;

  ////////////////////////////////////////////////////////////
  // Reference model from port traffic
  ////////////////////////////////////////////////////////////

  assign wr_hs     = axil_req.awvalid && axil_rsp.awready && axil_req.wvalid && axil_rsp.wready;
  assign ar_hs     = axil_req.arvalid && axil_rsp.arready;
  assign aw_idx    = axil_req.awaddr[IDX_HI:IDX_LO];
  assign ar_idx    = axil_req.araddr[IDX_HI:IDX_LO];
  assign cur_dest  = shadow[aes_pkg::DEST_REG][`AES_DEST_BITS-1:0];
  assign fips_cfg  = ({shadow[aes_pkg::KEY_HI_REG], shadow[aes_pkg::KEY_LO_REG]} == FIPS_KEY) &&
                     ({shadow[aes_pkg::IV_HI_REG], shadow[aes_pkg::IV_LO_REG]} == FIPS_PT);
  assign exp_beat  = sent[out_cnt[7:0]];
  assign keystream = out_beat.data ^ exp_beat.data;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      for (int r = 0; r < `AES_N_REGS; r++) begin
        shadow[r] <= '0;
      end
      rd_exp <= '0;
    end else begin
      if (wr_hs && (aw_idx < `AES_N_REGS)) begin
        for (int b = 0; b < `AES_AXIL_DATA_BITS / 8; b++) begin
          if (axil_req.wstrb[b]) begin
            shadow[aw_idx][8*b +: 8] <= axil_req.wdata[8*b +: 8];
          end
        end
      end
      // Key and IV halves read back, the rest as zero
      if (ar_hs) begin
        rd_exp <= (ar_idx < aes_pkg::DEST_REG) ? shadow[ar_idx] : '0;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      in_cnt    <= 0;
      out_cnt   <= 0;
      cred_cnt  <= 0;
      sink_cred <= `AES_FIFO_DEPTH;
      n_enc     <= 0;
    end else begin
      if (in_valid) begin
        in_cnt <= in_cnt + 1;
      end
      if (out_valid) begin
        out_cnt <= out_cnt + 1;
      end
      if (in_credit) begin
        cred_cnt <= cred_cnt + 1;
      end
      sink_cred <= sink_cred + int'(out_credit) - int'(out_valid);
      // Counter restarts at zero on a strobed DEST_REG write
      if (wr_hs && (aw_idx == aes_pkg::DEST_REG) && (|axil_req.wstrb)) begin
        n_enc <= 0;
      end else if (out_valid && out_beat.enc) begin
        n_enc <= n_enc + 1;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (in_valid) begin
      sent[in_cnt[7:0]] <= in_beat;
    end
  end

  ////////////////////////////////////////////////////////////
  // Register port
  ////////////////////////////////////////////////////////////

  a_bresp: assert property (@(posedge aclk) disable iff (!aresetn)
    axil_rsp.bvalid |-> axil_rsp.bresp == axil_pkg::RESP_OKAY)
  else begin
    $error("** Error %0t: axil_rsp.bresp %b, expected %b", $time,
           $sampled(axil_rsp.bresp), axil_pkg::RESP_OKAY);
    fail_cnt++;
  end

  a_rresp: assert property (@(posedge aclk) disable iff (!aresetn)
    axil_rsp.rvalid |-> axil_rsp.rresp == axil_pkg::RESP_OKAY)
  else begin
    $error("** Error %0t: axil_rsp.rresp %b, expected %b", $time,
           $sampled(axil_rsp.rresp), axil_pkg::RESP_OKAY);
    fail_cnt++;
  end

  a_rdata: assert property (@(posedge aclk) disable iff (!aresetn)
    axil_rsp.rvalid && axil_req.rready |-> axil_rsp.rdata == rd_exp)
  else begin
    $error("** Error %0t: axil_rsp.rdata %h, expected %h", $time,
           $sampled(axil_rsp.rdata), $sampled(rd_exp));
    fail_cnt++;
  end

  ////////////////////////////////////////////////////////////
  // Output stream contents and order
  ////////////////////////////////////////////////////////////

  a_dest: assert property (@(posedge aclk) disable iff (!aresetn)
    out_valid |-> out_beat.dest == exp_beat.dest)
  else begin
    $error("** Error %0t: out_beat.dest %0d, expected %0d", $time,
           $sampled(out_beat.dest), $sampled(exp_beat.dest));
    fail_cnt++;
  end

  a_enc: assert property (@(posedge aclk) disable iff (!aresetn)
    out_valid |-> out_beat.enc == (exp_beat.dest == cur_dest))
  else begin
    $error("** Error %0t: out_beat.enc %b, expected %b", $time,
           $sampled(out_beat.enc), $sampled(exp_beat.dest == cur_dest));
    fail_cnt++;
  end

  // Pass-through data untouched
  a_plain: assert property (@(posedge aclk) disable iff (!aresetn)
    out_valid && !out_beat.enc |-> out_beat.data == exp_beat.data)
  else begin
    $error("** Error %0t: out_beat.data %h, expected %h", $time,
           $sampled(out_beat.data), $sampled(exp_beat.data));
    fail_cnt++;
  end

  // First block after an IV write is AES(key, IV) itself
  a_kat: assert property (@(posedge aclk) disable iff (!aresetn)
    out_valid && out_beat.enc && fips_cfg && (n_enc == 0) |-> keystream == FIPS_CT)
  else begin
    $error("** Error %0t: keystream (out_beat.data ^ in data) %h, expected %h", $time,
           $sampled(keystream), FIPS_CT);
    fail_cnt++;
  end

  a_advance: assert property (@(posedge aclk) disable iff (!aresetn)
    out_valid && out_beat.enc && fips_cfg && (n_enc != 0) |-> keystream != FIPS_CT)
  else begin
    $error("Counter did not advance, a later block reused the first keystream");
    fail_cnt++;
  end

  ////////////////////////////////////////////////////////////
  // Credit safety
  ////////////////////////////////////////////////////////////

  a_sink_cred: assert property (@(posedge aclk) disable iff (!aresetn)
    out_valid |-> sink_cred > 0)
  else begin
    $error("Output beat sent while the sink had no credit left");
    fail_cnt++;
  end

  a_in_credit: assert property (@(posedge aclk) disable iff (!aresetn)
    in_credit |-> cred_cnt < in_cnt)
  else begin
    $error("Input credit returned for a beat that was never sent");
    fail_cnt++;
  end

  a_no_extra: assert property (@(posedge aclk) disable iff (!aresetn)
    out_valid |-> out_cnt < in_cnt)
  else begin
    $error("More output beats than input beats");
    fail_cnt++;
  end

endmodule

//--- tb_aes_top.sv
`timescale 1ns/10ps
`include "aes_defs.svh"

module tb_aes_top;

  // Cycles allowed for any single wait
  localparam int TIMEOUT = 5000;

  logic                   aclk;
  logic                   aresetn;
  axil_pkg::axil_req_t    axil_req;
  axil_pkg::axil_rsp_t    axil_rsp;
  logic                   in_valid;
  aes_pkg::aes_beat_t     in_beat;
  logic                   in_credit;
  logic                   out_valid;
  aes_pkg::aes_out_beat_t out_beat;
  logic                   out_credit = 1'b0;

  integer seed = 32'h4b80;
  // Source credits, beats sent and received
  int     src_cred;
  int     n_in = 0;
  int     n_out;
  // Sink credits not yet returned
  int     owed = 0;
  logic   stall = 1'b0;

  aes_top i_aes_top (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .axil_req   (axil_req),
    .axil_rsp   (axil_rsp),
    .in_valid   (in_valid),
    .in_beat    (in_beat),
    .in_credit  (in_credit),
    .out_valid  (out_valid),
    .out_beat   (out_beat),
    .out_credit (out_credit)
  );

  bind aes_top aes_asserts i_aes_asserts (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .axil_req   (axil_req),
    .axil_rsp   (axil_rsp),
    .in_valid   (in_valid),
    .in_beat    (in_beat),
    .in_credit  (in_credit),
    .out_valid  (out_valid),
    .out_beat   (out_beat),
    .out_credit (out_credit)
  );

  initial aclk = 1'b0;
  always #10 aclk = ~aclk;

  ////////////////////////////////////////////////////////////
  // Credit bookkeeping and sink
  ////////////////////////////////////////////////////////////

  always @(posedge aclk) begin
    if (!aresetn) begin
      src_cred <= `AES_FIFO_DEPTH;
      n_out    <= 0;
    end else begin
      src_cred <= src_cred + int'(in_credit) - int'(in_valid);
      if (out_valid) begin
        n_out <= n_out + 1;
      end
    end
  end

  // Credits return one cycle late and at random gaps while stalling
  always @(negedge aclk) begin
    if (!aresetn) begin
      owed       = 0;
      out_credit = 1'b0;
    end else begin
      out_credit = 1'b0;
      if ((owed > 0) && (!stall || (($random(seed) & 32'h3) == 0))) begin
        out_credit = 1'b1;
        owed       = owed - 1;
      end
      if (out_valid) begin
        owed = owed + 1;
      end
    end
  end

  // Stop at the first assertion failure
  always @(posedge aclk) begin
    if (i_aes_top.i_aes_asserts.fail_cnt != 0) begin
      $display("Checks failed");
      $fatal(1, "Assertion failure seen at %0t", $time);
    end
  end

  ////////////////////////////////////////////////////////////
  // Bus and stream tasks
  ////////////////////////////////////////////////////////////

  task automatic report_timeout(input string what);
    $display("Checks failed");
    $fatal(1, "Timeout at %0t waiting for %s", $time, what);
  endtask

  task automatic write_reg(input int idx, input logic [63:0] data, input logic [7:0] strb);
    int t;
    t = 0;
    @(negedge aclk);
    axil_req.awaddr  = `AES_AXIL_ADDR_BITS'(idx * 8);
    axil_req.awvalid = 1'b1;
    axil_req.wdata   = data;
    axil_req.wstrb   = strb;
    axil_req.wvalid  = 1'b1;
    while (!(axil_rsp.awready && axil_rsp.wready)) begin
      @(negedge aclk);
      t++;
      if (t > TIMEOUT) report_timeout("awready and wready");
    end
    // Accepted at the rising edge just passed
    @(negedge aclk);
    axil_req.awvalid = 1'b0;
    axil_req.wvalid  = 1'b0;
    t = 0;
    while (!axil_rsp.bvalid) begin
      @(negedge aclk);
      t++;
      if (t > TIMEOUT) report_timeout("bvalid");
    end
  endtask

  task automatic read_reg(input int idx);
    int t;
    t = 0;
    @(negedge aclk);
    axil_req.araddr  = `AES_AXIL_ADDR_BITS'(idx * 8);
    axil_req.arvalid = 1'b1;
    while (!axil_rsp.arready) begin
      @(negedge aclk);
      t++;
      if (t > TIMEOUT) report_timeout("arready");
    end
    @(negedge aclk);
    axil_req.arvalid = 1'b0;
    t = 0;
    while (!axil_rsp.rvalid) begin
      @(negedge aclk);
      t++;
      if (t > TIMEOUT) report_timeout("rvalid");
    end
  endtask

  // One beat per source credit
  task automatic send_beat(input aes_pkg::aes_block_t data,
                           input logic [`AES_DEST_BITS-1:0] dest);
    int t;
    t = 0;
    @(negedge aclk);
    while (src_cred == 0) begin
      @(negedge aclk);
      t++;
      if (t > TIMEOUT) report_timeout("an input credit");
    end
    in_valid     = 1'b1;
    in_beat.data = data;
    in_beat.dest = dest;
    n_in++;
    @(negedge aclk);
    in_valid = 1'b0;
  endtask

  task automatic wait_drain();
    int t;
    t = 0;
    while (n_out != n_in) begin
      @(negedge aclk);
      t++;
      if (t > TIMEOUT) report_timeout("all sent beats to leave the output");
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  initial begin
    int r;
    axil_req        = '0;
    axil_req.bready = 1'b1;
    axil_req.rready = 1'b1;
    in_valid        = 1'b0;
    in_beat         = '0;
    aresetn         = 1'b0;
    repeat (8) @(posedge aclk);
    @(negedge aclk);
    aresetn = 1'b1;

    // Readback after a full write and a partial one over it
    for (r = 0; r <= aes_pkg::IV_HI_REG; r++) begin
      write_reg(r, {2{32'hc3a50f1e ^ (r * 32'h01010101)}}, 8'hff);
      write_reg(r, 64'h0123456789abcdef + r, 8'h5a);
      read_reg(r);
    end

    // FIPS key, IV = FIPS plaintext, dest 3
    write_reg(aes_pkg::KEY_LO_REG, 64'h08090a0b0c0d0e0f, 8'hff);
    write_reg(aes_pkg::KEY_HI_REG, 64'h0001020304050607, 8'hff);
    write_reg(aes_pkg::IV_LO_REG, 64'h8899aabbccddeeff, 8'hff);
    write_reg(aes_pkg::IV_HI_REG, 64'h0011223344556677, 8'hff);
    write_reg(aes_pkg::DEST_REG, 64'd3, 8'hff);
    // Nonzero destination still reads as zero
    read_reg(aes_pkg::DEST_REG);

    // Known answer with pass-through beats between two ciphered ones
    send_beat('0, 6'd3);
    send_beat(128'h0f1e2d3c4b5a69788796a5b4c3d2e1f0, 6'd5);
    send_beat(128'h55aa55aa00ff00ff12345678deadbeef, 6'd9);
    send_beat('0, 6'd3);
    send_beat(128'hffffffffffffffff0000000000000000, 6'd5);
    wait_drain();

    // New DEST write restarts the counter
    write_reg(aes_pkg::DEST_REG, 64'd3, 8'hff);
    send_beat('0, 6'd3);
    send_beat(128'h1, 6'd7);
    wait_drain();

    // Random sink stalls
    @(posedge aclk) stall = 1'b1;
    for (r = 0; r < 24; r++) begin
      send_beat({4{32'h9e3779b9 * (r + 1)}},
                (r % 3 == 0) ? 6'd3 : ((r % 3 == 1) ? 6'd5 : 6'd7));
    end
    wait_drain();
    @(posedge aclk) stall = 1'b0;
    repeat (4) @(negedge aclk);

    if (i_aes_top.i_aes_asserts.fail_cnt == 0) begin
      $display("All checks passed");
      $finish;
    end else begin
      $display("Checks failed");
      $fatal(1, "%0d assertion failures", i_aes_top.i_aes_asserts.fail_cnt);
    end
  end

endmodule

//--- verilog.f
+incdir+.
axil_pkg.sv
aes_pkg.sv
aes_sbox.sv
aes_stream_fifo.sv
aes_ctrl_parser.sv
aes_ctr_engine.sv
aes_top.sv
aes_asserts.sv
tb_aes_top.sv
